//--- design/mrd_consts.svh
// Sample memory sizes
`ifndef MRD_CONSTS_SVH
`define MRD_CONSTS_SVH

// ----------------------------------------------------------------------
// Data path
// ----------------------------------------------------------------------

// Real and imaginary part, each
`define MRD_DW 18

// ----------------------------------------------------------------------
// Memory organisation
// ----------------------------------------------------------------------

`define MRD_BANKS 7 // Bank = linear address mod 7

`define MRD_BANK_DEPTH 256 // Rows per bank

// Linear address, frames up to 1792 samples
`define MRD_AW 12

// One factor of the prime-factor map
`define MRD_FW 10

`define MRD_ROW_AW 8 // Row = linear address div 7

`endif

//--- design/mrd_pkg.sv
// Sample memory types
package mrd_pkg;

	`include "mrd_consts.svh"

	// ------------------------------------------------------------------
	// Streams
	// ------------------------------------------------------------------

	typedef struct packed
	{
		logic                     sop;
		logic signed [`MRD_DW-1:0] re;
		logic signed [`MRD_DW-1:0] im;
	} mrd_in_t;

	typedef struct packed
	{
		logic                     sop;
		logic                     eop;
		logic signed [`MRD_DW-1:0] re;
		logic signed [`MRD_DW-1:0] im;
	} mrd_out_t;

	// Coprime factors, frame length is nf1 * nf2 * nf3
	typedef struct packed
	{
		logic [`MRD_FW-1:0] nf1;
		logic [`MRD_FW-1:0] nf2;
		logic [`MRD_FW-1:0] nf3;
	} mrd_cfg_t;

	// ------------------------------------------------------------------
	// Buffer side
	// ------------------------------------------------------------------

	typedef struct packed
	{
		logic [2:0]                bank;
		logic [`MRD_ROW_AW-1:0]    row;
		logic signed [`MRD_DW-1:0] re;
		logic signed [`MRD_DW-1:0] im;
	} mrd_wr_t;

	typedef struct packed
	{
		logic [2:0]             bank;
		logic [`MRD_ROW_AW-1:0] row;
	} mrd_rd_t;

	typedef struct packed
	{
		logic [`MRD_AW-1:0] len; // Stored samples
	} mrd_frame_t;

	typedef enum logic [1:0] {SINK_IDLE, SINK_RUN, SINK_HOLD} mrd_sink_state_e;

	typedef enum logic [1:0] {SRC_IDLE, SRC_READ, SRC_DRAIN} mrd_src_state_e;

endpackage

//--- design/mrd_sink_map.sv
// Input sample mapper
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_sink_map (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  mrd_pkg::mrd_in_t       in_data,
	input  mrd_pkg::mrd_cfg_t      cfg,
	input  logic                   frame_free,
	output logic                   wr_en,
	output mrd_pkg::mrd_wr_t       wr,
	output logic                   frame_done,
	output mrd_pkg::mrd_frame_t    frame
);

	import mrd_pkg::*;

	function automatic logic [`MRD_FW-1:0] inc_mod(input logic [`MRD_FW-1:0] d,
	                                                input logic [`MRD_FW-1:0] n);
		return (d == n - 1'b1) ? '0 : d + 1'b1;
	endfunction

	mrd_sink_state_e    state;
	mrd_cfg_t           cfg_r;
	mrd_cfg_t           cur_cfg;
	logic [`MRD_AW-1:0] len_r, cur_len;
	logic [`MRD_AW-1:0] smp_cnt;
	logic [`MRD_FW-1:0] d1, d2, d3;       // Digits of the next sample
	logic [`MRD_FW-1:0] d1_r, d2_r, d3_r; // Digits of the sample being written
	logic signed [`MRD_DW-1:0] re_r, im_r;
	logic               wr_vld_r, wr_last_r;
	logic               take, last;
	logic [`MRD_AW-1:0] lin_addr, row_full;

	assign in_ready = (state != SINK_HOLD);

	// Before sop nothing is stored
	assign take = in_valid && in_ready && (state == SINK_RUN || in_data.sop);

	// Factors come straight from cfg on the sop beat
	assign cur_cfg = (state == SINK_IDLE) ? cfg : cfg_r;
	assign cur_len = (state == SINK_IDLE) ? `MRD_AW'(cfg.nf1 * cfg.nf2 * cfg.nf3) : len_r;
	assign last    = take && (`MRD_AW'(smp_cnt + 1'b1) == cur_len);

	// ------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state      <= SINK_IDLE;
			smp_cnt    <= '0;
			d1         <= '0;
			d2         <= '0;
			d3         <= '0;
			wr_vld_r   <= 1'b0;
			wr_last_r  <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			wr_vld_r   <= take;
			wr_last_r  <= last;
			frame_done <= wr_vld_r && wr_last_r; // One cycle after the last write

			case (state)
				SINK_IDLE: if (take) state <= last ? SINK_HOLD : SINK_RUN;
				SINK_RUN:  if (last) state <= SINK_HOLD;
				SINK_HOLD: if (frame_free) state <= SINK_IDLE;
				default:   state <= SINK_IDLE;
			endcase

			if (last)
			begin
				smp_cnt <= '0;
				d1      <= '0;
				d2      <= '0;
				d3      <= '0;
			end
			else if (take)
			begin
				smp_cnt <= smp_cnt + 1'b1;
				d1      <= inc_mod(d1, cur_cfg.nf1);
				d2      <= inc_mod(d2, cur_cfg.nf2);
				d3      <= inc_mod(d3, cur_cfg.nf3);
			end
		end
	end

	// Payload stage
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			d1_r <= d1;
			d2_r <= d2;
			d3_r <= d3;
			re_r <= in_data.re;
			im_r <= in_data.im;
		end
		if (take && state == SINK_IDLE)
		begin
			cfg_r <= cfg;
			len_r <= cur_len;
		end
		if (wr_vld_r && wr_last_r)
			frame.len <= len_r;
	end

	// ------------------------------------------------------------------
	// Address and bank split
	// ------------------------------------------------------------------
	assign lin_addr = d1_r * cfg_r.nf2 * cfg_r.nf3 + d2_r * cfg_r.nf3 + d3_r;
	assign row_full = lin_addr / `MRD_AW'(`MRD_BANKS);

	assign wr_en = wr_vld_r;

	always_comb
	begin
		wr.bank = 3'(lin_addr % `MRD_AW'(`MRD_BANKS));
		wr.row  = row_full[`MRD_ROW_AW-1:0];
		wr.re   = re_r;
		wr.im   = im_r;
	end

endmodule

//--- design/mrd_bank_mem.sv
// Seven bank sample buffer
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_bank_mem (
	input  logic                      clk,
	input  logic                      wr_en,
	input  mrd_pkg::mrd_wr_t          wr,
	input  logic                      rd_en,
	input  mrd_pkg::mrd_rd_t          rd,
	output logic signed [`MRD_DW-1:0] rd_re,
	output logic signed [`MRD_DW-1:0] rd_im
);

	import mrd_pkg::*;

	logic [`MRD_BANKS-1:0]   wr_sel;
	logic [`MRD_BANKS-1:0]   rd_sel;
	logic [2*`MRD_DW-1:0]    bank_q [`MRD_BANKS];
	logic [2:0]              rd_bank_r; // Bank of the read in progress

	// One-hot bank decode
	always_comb
	begin
		wr_sel = '0;
		rd_sel = '0;
		if (wr_en)
			wr_sel[wr.bank] = 1'b1;
		if (rd_en)
			rd_sel[rd.bank] = 1'b1;
	end

	// ------------------------------------------------------------------
	// Banks
	// ------------------------------------------------------------------
	for (genvar b = 0; b < `MRD_BANKS; b++)
	begin : g_bank
		logic [2*`MRD_DW-1:0] mem [`MRD_BANK_DEPTH];
		logic [2*`MRD_DW-1:0] dout;

		always_ff @(posedge clk)
		begin
			if (wr_sel[b])
				mem[wr.row] <= {wr.re, wr.im};
			if (rd_sel[b])
				dout <= mem[rd.row];
		end

		assign bank_q[b] = dout;
	end

	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_bank_r <= rd.bank;
	end

	// Only the addressed bank holds fresh data
	assign rd_re = bank_q[rd_bank_r][2*`MRD_DW-1:`MRD_DW];
	assign rd_im = bank_q[rd_bank_r][`MRD_DW-1:0];

endmodule

//--- design/mrd_source_read.sv
// Linear order frame reader
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_source_read (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      frame_done,
	input  mrd_pkg::mrd_frame_t       frame,
	output logic                      rd_en,
	output mrd_pkg::mrd_rd_t          rd,
	input  logic signed [`MRD_DW-1:0] rd_re,
	input  logic signed [`MRD_DW-1:0] rd_im,
	output logic                      out_valid,
	input  logic                      out_ready,
	output mrd_pkg::mrd_out_t         out_data,
	output logic                      frame_free
);

	import mrd_pkg::*;

	mrd_src_state_e         state;
	logic [`MRD_AW-1:0]     len_r;
	logic [`MRD_AW-1:0]     rd_addr; // Linear read address
	logic [2:0]             rd_bank;
	logic [`MRD_ROW_AW-1:0] rd_row;
	logic                   rd_vld_r; // Read data arrives this cycle
	logic                   rd_sop_r, rd_eop_r;
	logic                   addr_last;

	// Two-entry output queue
	mrd_out_t               q [2];
	logic                   q_wr_ptr, q_rd_ptr;
	logic [1:0]             q_cnt;
	logic [2:0]             fill_after;
	logic                   issue, pop;

	assign addr_last = (rd_addr == len_r - 1'b1);
	assign pop       = out_valid && out_ready;

	// Entries held after this edge, counting the read returning now
	assign fill_after = 3'(q_cnt) + 3'(rd_vld_r) - 3'(pop);
	assign issue      = (state == SRC_READ) && (fill_after < 3'd2);

	assign rd_en   = issue;
	assign rd.bank = rd_bank;
	assign rd.row  = rd_row;

	// ------------------------------------------------------------------
	// Read address and state
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state      <= SRC_IDLE;
			rd_addr    <= '0;
			rd_bank    <= '0;
			rd_row     <= '0;
			rd_vld_r   <= 1'b0;
			frame_free <= 1'b0;
		end
		else
		begin
			rd_vld_r   <= issue;
			frame_free <= pop && out_data.eop;

			case (state)
				SRC_IDLE:
				begin
					rd_addr <= '0;
					rd_bank <= '0;
					rd_row  <= '0;
					if (frame_done)
						state <= SRC_READ;
				end
				SRC_READ:
				begin
					if (issue)
					begin
						rd_addr <= rd_addr + 1'b1;
						if (rd_bank == 3'(`MRD_BANKS - 1)) // Wrap to next row
						begin
							rd_bank <= '0;
							rd_row  <= rd_row + 1'b1;
						end
						else
							rd_bank <= rd_bank + 1'b1;
						if (addr_last)
							state <= SRC_DRAIN;
					end
				end
				SRC_DRAIN: if (pop && out_data.eop) state <= SRC_IDLE;
				default:   state <= SRC_IDLE;
			endcase
		end
	end

	// Frame length and tags travel alongside the read
	always_ff @(posedge clk)
	begin
		if (state == SRC_IDLE && frame_done)
			len_r <= frame.len;
		rd_sop_r <= (rd_addr == '0);
		rd_eop_r <= addr_last;
	end

	// ------------------------------------------------------------------
	// Output queue
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			q_cnt    <= '0;
			q_wr_ptr <= 1'b0;
			q_rd_ptr <= 1'b0;
		end
		else
		begin
			q_cnt <= q_cnt + 2'(rd_vld_r) - 2'(pop);
			if (rd_vld_r)
				q_wr_ptr <= ~q_wr_ptr;
			if (pop)
				q_rd_ptr <= ~q_rd_ptr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_vld_r)
			q[q_wr_ptr] <= '{sop: rd_sop_r, eop: rd_eop_r, re: rd_re, im: rd_im};
	end

	assign out_valid = (q_cnt != '0);
	assign out_data  = q[q_rd_ptr]; // Head stays put until popped

endmodule

//--- design/mrd_mem_top.sv
// Sample memory top
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_mem_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	output logic               in_ready,
	input  mrd_pkg::mrd_in_t   in_data,
	input  mrd_pkg::mrd_cfg_t  cfg,
	output logic               out_valid,
	input  logic               out_ready,
	output mrd_pkg::mrd_out_t  out_data
);

	import mrd_pkg::*;

	logic                      wr_en, rd_en;
	mrd_wr_t                   wr;
	mrd_rd_t                   rd;
	logic signed [`MRD_DW-1:0] rd_re, rd_im;
	logic                      frame_done, frame_free;
	mrd_frame_t                frame;

	// Prime-factor input map into the banks
	mrd_sink_map mrd_sink_map_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_data    (in_data),
		.cfg        (cfg),
		.frame_free (frame_free),
		.wr_en      (wr_en),
		.wr         (wr),
		.frame_done (frame_done),
		.frame      (frame)
	);

	mrd_bank_mem mrd_bank_mem_i (
		.clk   (clk),
		.wr_en (wr_en),
		.wr    (wr),
		.rd_en (rd_en),
		.rd    (rd),
		.rd_re (rd_re),
		.rd_im (rd_im)
	);

	mrd_source_read mrd_source_read_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.frame      (frame),
		.rd_en      (rd_en),
		.rd         (rd),
		.rd_re      (rd_re),
		.rd_im      (rd_im),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.frame_free (frame_free) // Releases the producer
	);

endmodule

//--- verif/mrd_mem_properties.sv
// Sample memory stream assertions
`timescale 1ns/1ps

module mrd_mem_properties (
	input logic              clk,
	input logic              rst_n,
	input logic              in_valid,
	input logic              in_ready,
	input logic              out_valid,
	input logic              out_ready,
	input mrd_pkg::mrd_out_t out_data,
	input logic              frame_done,
	input logic              frame_free
);

	int   fail_cnt = 0;
	logic held; // Frame stored and not yet drained

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			held <= 1'b0;
		else if (frame_done)
			held <= 1'b1;
		else if (frame_free)
			held <= 1'b0;
	end

	// Output beat waits unchanged for out_ready
	out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
	else
	begin
		$error("out_data changed before it was accepted");
		fail_cnt++;
	end

	no_input_while_held: assert property (@(posedge clk) disable iff (!rst_n)
		held |-> !(in_valid && in_ready))
	else
	begin
		$error("input beat accepted while a frame is held");
		fail_cnt++;
	end

	reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
	else
	begin
		$error("out_valid high after reset");
		fail_cnt++;
	end

endmodule

bind mrd_mem_top mrd_mem_properties mrd_mem_properties_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_valid   (in_valid),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_data   (out_data),
	.frame_done (frame_done),
	.frame_free (frame_free)
);

//--- verif/mrd_mem_tb.sv
// Sample memory testbench
`timescale 1ns/1ps
`include "mrd_consts.svh"

module mrd_mem_tb;

	import mrd_pkg::*;

	localparam int TIMEOUT_CYC = 4000;

	logic     clk = 1'b0;
	logic     rst_n, in_valid, in_ready, out_valid, out_ready;
	mrd_in_t  in_data;
	mrd_cfg_t cfg;
	mrd_out_t out_data;
	int       cyc = 0;
	mrd_out_t exp_q [$]; // Expected outputs in linear order

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	mrd_mem_top mrd_mem_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.cfg       (cfg),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	// ------------------------------------------------------------------
	// Checking
	// ------------------------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string name);
		if (got !== exp)
			stop_on_error($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
	endtask

	// Bound stream assertions
	always @(negedge clk)
		if (mrd_mem_top_i.mrd_mem_properties_i.fail_cnt != 0)
			stop_on_error("a stream assertion failed");

	// ------------------------------------------------------------------
	// Stimulus and reference model
	// ------------------------------------------------------------------
	task automatic send_beat(input mrd_in_t d, output int acc_cyc);
		int waited;
		waited   = 0;
		in_data  = d;
		in_valid = 1'b1;
		while (!in_ready)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > TIMEOUT_CYC)
				stop_on_error("timeout waiting for in_ready");
		end
		acc_cyc = cyc; // Transfers at the coming edge
		@(posedge clk);
		#1;
	endtask

	task automatic send_frame(input int n1, input int n2, input int n3, output int first_cyc);
		int       n, m, c;
		mrd_in_t  smp [];
		mrd_out_t exp_f [];
		n     = n1 * n2 * n3;
		smp   = new[n];
		exp_f = new[n];
		for (int k = 0; k < n; k++)
		begin
			smp[k].sop = (k == 0);
			smp[k].re  = `MRD_DW'($urandom);
			smp[k].im  = `MRD_DW'($urandom);
			m = (k % n1) * n2 * n3 + (k % n2) * n3 + (k % n3); // Prime-factor input map
			exp_f[m] = '{sop: (m == 0), eop: (m == n - 1), re: smp[k].re, im: smp[k].im};
		end
		for (int i = 0; i < n; i++)
			exp_q.push_back(exp_f[i]);
		cfg = '{nf1: `MRD_FW'(n1), nf2: `MRD_FW'(n2), nf3: `MRD_FW'(n3)};
		for (int k = 0; k < n; k++)
		begin
			send_beat(smp[k], c);
			if (k == 0)
				first_cyc = c;
		end
		in_valid = 1'b0;
	endtask

	task automatic recv_outputs(input int total, input int mark, input bit rnd,
	                            output int mark_cyc);
		int       got, idle;
		mrd_out_t exp;
		got      = 0;
		idle     = 0;
		mark_cyc = -1;
		while (got < total)
		begin
			out_ready = rnd ? 1'($urandom) : 1'b1;
			if (out_valid && out_ready)
			begin
				exp = exp_q.pop_front();
				check_equal(64'(out_data), 64'(exp), $sformatf("out_data[%0d]", got));
				if (got == mark)
					mark_cyc = cyc;
				got++;
				idle = 0;
			end
			else
			begin
				idle++;
				if (idle > TIMEOUT_CYC)
					stop_on_error("timeout waiting for out_valid");
			end
			@(posedge clk);
			#1;
		end
		out_ready = 1'b0;
	endtask

	task automatic expect_idle();
		repeat (3) @(posedge clk);
		#1;
		check_equal(64'(out_valid), 64'(0), "out_valid");
		check_equal(64'(in_ready), 64'(1), "in_ready"); // Producer released
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic test_reset();
		check_equal(64'(in_ready), 64'(1), "in_ready");
		check_equal(64'(out_valid), 64'(0), "out_valid");
	endtask

	task automatic test_frame_30();
		int c, f, mk;
		fork
			begin
				send_beat('{sop: 1'b0, re: `MRD_DW'(5), im: `MRD_DW'(9)}, c); // Dropped
				send_frame(2, 3, 5, f);
			end
			recv_outputs(30, -1, 1'b0, mk);
		join
		expect_idle();
	endtask

	task automatic test_frame_504();
		int f, mk;
		fork
			send_frame(7, 8, 9, f);
			recv_outputs(504, -1, 1'b1, mk);
		join
		expect_idle();
	endtask

	task automatic test_hold();
		int a_first, b_first, a_last;
		fork
			begin
				send_frame(2, 3, 5, a_first);
				send_frame(3, 4, 5, b_first); // Offered right away
			end
			recv_outputs(90, 29, 1'b1, a_last);
		join
		check_equal(64'(b_first > a_last), 64'(1), "second frame start after first frame end");
		expect_idle();
	endtask

	task automatic test_identity();
		int f, mk;
		fork
			send_frame(1, 1, 4, f);
			recv_outputs(4, -1, 1'b0, mk);
		join
		expect_idle();
	endtask

	initial
	begin
		void'($urandom(38));
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		cfg       = '0;
		out_ready = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_frame_30();
		test_frame_504();
		test_hold();
		test_identity();
		if (mrd_mem_top_i.mrd_mem_properties_i.fail_cnt == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
			stop_on_error("a stream assertion failed");
	end

endmodule

//--- all.f
+incdir+design
design/mrd_pkg.sv
design/mrd_sink_map.sv
design/mrd_bank_mem.sv
design/mrd_source_read.sv
design/mrd_mem_top.sv
verif/mrd_mem_properties.sv
verif/mrd_mem_tb.sv

//--- Bender.yml
package:
  name: mrd_mem

sources:
  - include_dirs:
      - design
    files:
      - design/mrd_pkg.sv
      - design/mrd_sink_map.sv
      - design/mrd_bank_mem.sv
      - design/mrd_source_read.sv
      - design/mrd_mem_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/mrd_mem_properties.sv
      - verif/mrd_mem_tb.sv
